//--- cpu_mem_pkg.sv
`default_nettype none

package cpu_mem_pkg;

  // ======================================================================
  // Line geometry
  // ======================================================================
  localparam int LINE_BYTES    = 16;
  localparam int LINE_WORDS    = 4;
  localparam int LINE_OFF_BITS = $clog2(LINE_BYTES);

  // Load and store sizes
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_t;

  // One memory line, byte view for store merging, word view for fetch
  typedef union packed {
    logic [LINE_BYTES-1:0][7:0]  bytes;
    logic [LINE_WORDS-1:0][31:0] words;
  } line_t;

endpackage

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter #(
  parameter int PADDR_WIDTH = 16
)(
  input  logic clk_i,
  input  logic rst_i,

  // Fetch requester
  input  logic ifu_req_i,
  input  logic [PADDR_WIDTH-cpu_mem_pkg::LINE_OFF_BITS-1:0] ifu_addr_i,
  output logic ifu_done_o,
  output cpu_mem_pkg::line_t ifu_rdata_o,

  // Data requester
  input  logic lsu_req_i,
  input  logic lsu_we_i,
  input  logic [PADDR_WIDTH-cpu_mem_pkg::LINE_OFF_BITS-1:0] lsu_addr_i,
  input  cpu_mem_pkg::line_t lsu_wdata_i,
  output logic lsu_done_o,
  output cpu_mem_pkg::line_t lsu_rdata_o,

  // Wishbone classic master
  output logic wb_cyc_o,
  output logic wb_stb_o,
  output logic wb_we_o,
  output logic [PADDR_WIDTH-cpu_mem_pkg::LINE_OFF_BITS-1:0] wb_adr_o,
  output cpu_mem_pkg::line_t wb_dat_o,
  input  cpu_mem_pkg::line_t wb_dat_i,
  input  logic wb_ack_i
);
  import cpu_mem_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUS  = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0] state_q;
  logic owner_lsu_q;
  line_t rdata_q;

  // ======================================================================
  // Grant and bus FSM
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q     <= ST_IDLE;
      owner_lsu_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // Data side wins a tie
          if (lsu_req_i || ifu_req_i) begin
            state_q     <= ST_BUS;
            owner_lsu_q <= lsu_req_i;
          end
        end
        ST_BUS: begin
          if (wb_ack_i) begin
            state_q <= ST_DONE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Request registered at grant, held through the bus cycle
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) begin
      wb_adr_o <= lsu_req_i ? lsu_addr_i : ifu_addr_i;
      wb_we_o  <= lsu_req_i && lsu_we_i;
      wb_dat_o <= lsu_wdata_i;
    end
    if (state_q == ST_BUS && wb_ack_i) begin
      rdata_q <= wb_dat_i;
    end
  end

  // Single transfer per cycle, so stb follows cyc
  assign wb_cyc_o = (state_q == ST_BUS);
  assign wb_stb_o = wb_cyc_o;

  // Done and line go to the owner only
  assign ifu_done_o  = (state_q == ST_DONE) && !owner_lsu_q;
  assign lsu_done_o  = (state_q == ST_DONE) && owner_lsu_q;
  assign ifu_rdata_o = owner_lsu_q ? '0 : rdata_q;
  assign lsu_rdata_o = owner_lsu_q ? rdata_q : '0;

endmodule

`default_nettype wire

//--- instr_fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fetch_unit #(
  parameter int PADDR_WIDTH = 16,
  parameter logic [PADDR_WIDTH-1:0] RESET_PC = '0
)(
  input  logic clk_i,
  input  logic rst_i,

  // Instruction stream
  input  logic fetch_ready_i,
  input  logic redirect_i,
  input  logic [PADDR_WIDTH-1:0] redirect_pc_i,
  output logic fetch_valid_o,
  output logic [PADDR_WIDTH-1:0] fetch_pc_o,
  output logic [31:0] fetch_instr_o,

  // Refill port to the arbiter
  output logic mem_req_o,
  output logic [PADDR_WIDTH-cpu_mem_pkg::LINE_OFF_BITS-1:0] mem_addr_o,
  input  logic mem_done_i,
  input  cpu_mem_pkg::line_t mem_rdata_i
);
  import cpu_mem_pkg::*;

  localparam int TAG_WIDTH = PADDR_WIDTH - LINE_OFF_BITS;

  logic [PADDR_WIDTH-1:0] pc_q;
  logic [TAG_WIDTH-1:0] pc_tag;

  line_t buf_line_q;
  logic [TAG_WIDTH-1:0] buf_tag_q;
  logic buf_valid_q;

  logic req_q;
  logic [TAG_WIDTH-1:0] req_tag_q;

  logic hit;

  assign pc_tag = pc_q[PADDR_WIDTH-1:LINE_OFF_BITS];
  assign hit    = buf_valid_q && (buf_tag_q == pc_tag);

  // ======================================================================
  // PC and refill control
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q        <= RESET_PC;
      buf_valid_q <= 1'b0;
      req_q       <= 1'b0;
    end else begin
      // Redirect beats consumption
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (hit && fetch_ready_i) begin
        pc_q <= pc_q + PADDR_WIDTH'(4);
      end

      if (mem_done_i) begin
        req_q       <= 1'b0;
        buf_valid_q <= 1'b1;
      end else if (!hit && !req_q) begin
        req_q <= 1'b1;
      end
    end
  end

  // Tag latched with the request, so a redirect mid-refill
  // still labels the returning line correctly
  always_ff @(posedge clk_i) begin
    if (!hit && !req_q) begin
      req_tag_q <= pc_tag;
    end
    if (mem_done_i) begin
      buf_line_q <= mem_rdata_i;
      buf_tag_q  <= req_tag_q;
    end
  end

  assign mem_req_o  = req_q;
  assign mem_addr_o = req_tag_q;

  assign fetch_valid_o = hit;
  assign fetch_pc_o    = pc_q;
  assign fetch_instr_o = buf_line_q.words[pc_q[LINE_OFF_BITS-1:2]];

endmodule

`default_nettype wire

//--- data_access_unit.sv
`timescale 1ns/10ps
`default_nettype none

module data_access_unit #(
  parameter int PADDR_WIDTH = 16
)(
  input  logic clk_i,
  input  logic rst_i,

  // Load/store requests
  input  logic req_i,
  input  logic we_i,
  input  logic [PADDR_WIDTH-1:0] addr_i,
  input  cpu_mem_pkg::access_size_t size_i,
  input  logic [31:0] wdata_i,
  output logic busy_o,
  output logic done_o,
  output logic [31:0] rdata_o,

  // Line port to the arbiter
  output logic mem_req_o,
  output logic mem_we_o,
  output logic [PADDR_WIDTH-cpu_mem_pkg::LINE_OFF_BITS-1:0] mem_addr_o,
  output cpu_mem_pkg::line_t mem_wdata_o,
  input  logic mem_done_i,
  input  cpu_mem_pkg::line_t mem_rdata_i
);
  import cpu_mem_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;
  localparam logic [1:0] ST_DONE  = 2'd3;

  logic [1:0] state_q;
  logic accept;

  logic [PADDR_WIDTH-1:0] addr_q;
  logic we_q;
  access_size_t size_q;
  logic [31:0] wdata_q;
  line_t line_q;
  logic [31:0] rdata_q;

  logic [LINE_OFF_BITS-1:0] offset;
  logic [LINE_OFF_BITS-1:0] nbytes;
  logic [LINE_OFF_BITS-1:0] base;
  line_t merged;
  logic [31:0] load_data;

  assign busy_o = (state_q == ST_READ) || (state_q == ST_WRITE);
  assign accept = req_i && !busy_o;

  // ======================================================================
  // Sequencing: read the line, then write it back for stores
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_READ: begin
          if (mem_done_i) begin
            state_q <= we_q ? ST_WRITE : ST_DONE;
          end
        end
        ST_WRITE: begin
          if (mem_done_i) begin
            state_q <= ST_DONE;
          end
        end
        default: begin
          state_q <= accept ? ST_READ : ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      size_q  <= size_i;
      wdata_q <= wdata_i;
    end
    if (state_q == ST_READ && mem_done_i) begin
      if (we_q) begin
        line_q <= merged;
      end else begin
        rdata_q <= load_data;
      end
    end
  end

  // ======================================================================
  // Byte lane selection
  // ======================================================================
  assign offset = addr_q[LINE_OFF_BITS-1:0];

  always_comb begin
    case (size_q)
      SIZE_BYTE: nbytes = LINE_OFF_BITS'(1);
      SIZE_HALF: nbytes = LINE_OFF_BITS'(2);
      default:   nbytes = LINE_OFF_BITS'(4);
    endcase
    // Low address bits below the size are ignored
    base = offset & ~(nbytes - LINE_OFF_BITS'(1));
  end

  // Store merge through the byte view
  always_comb begin
    merged = mem_rdata_i;
    for (int k = 0; k < 4; k++) begin
      if (k < nbytes) begin
        merged.bytes[base + LINE_OFF_BITS'(k)] = wdata_q[8*k +: 8];
      end
    end
  end

  // Zero-extended load
  always_comb begin
    case (size_q)
      SIZE_BYTE: load_data = {24'b0, mem_rdata_i.bytes[offset]};
      SIZE_HALF: load_data = {16'b0,
                              mem_rdata_i.bytes[{base[LINE_OFF_BITS-1:1], 1'b1}],
                              mem_rdata_i.bytes[base]};
      default:   load_data = mem_rdata_i.words[offset[LINE_OFF_BITS-1:2]];
    endcase
  end

  assign mem_req_o   = busy_o;
  assign mem_we_o    = (state_q == ST_WRITE);
  assign mem_addr_o  = addr_q[PADDR_WIDTH-1:LINE_OFF_BITS];
  assign mem_wdata_o = line_q;

  assign done_o  = (state_q == ST_DONE);
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- cpu_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_mem_port #(
  parameter int PADDR_WIDTH = 16,
  parameter logic [PADDR_WIDTH-1:0] RESET_PC = '0
)(
  input  logic clk_i,
  input  logic rst_i,

  // Instruction stream
  input  logic fetch_ready_i,
  input  logic redirect_i,
  input  logic [PADDR_WIDTH-1:0] redirect_pc_i,
  output logic fetch_valid_o,
  output logic [PADDR_WIDTH-1:0] fetch_pc_o,
  output logic [31:0] fetch_instr_o,

  // Load/store requests
  input  logic lsu_req_i,
  input  logic lsu_we_i,
  input  logic [PADDR_WIDTH-1:0] lsu_addr_i,
  input  cpu_mem_pkg::access_size_t lsu_size_i,
  input  logic [31:0] lsu_wdata_i,
  output logic lsu_busy_o,
  output logic lsu_done_o,
  output logic [31:0] lsu_rdata_o,

  // Wishbone classic master
  output logic wb_cyc_o,
  output logic wb_stb_o,
  output logic wb_we_o,
  output logic [PADDR_WIDTH-cpu_mem_pkg::LINE_OFF_BITS-1:0] wb_adr_o,
  output cpu_mem_pkg::line_t wb_dat_o,
  input  cpu_mem_pkg::line_t wb_dat_i,
  input  logic wb_ack_i
);
  import cpu_mem_pkg::*;

  // Fetch side request port
  logic ifu_req;
  logic [PADDR_WIDTH-LINE_OFF_BITS-1:0] ifu_addr;
  logic ifu_done;
  line_t ifu_rdata;

  // Data side request port
  logic lsu_mreq;
  logic lsu_mwe;
  logic [PADDR_WIDTH-LINE_OFF_BITS-1:0] lsu_maddr;
  line_t lsu_mwdata;
  logic lsu_mdone;
  line_t lsu_mrdata;

  mem_arbiter #(
    .PADDR_WIDTH (PADDR_WIDTH)
  ) mem_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ifu_req_i   (ifu_req),
    .ifu_addr_i  (ifu_addr),
    .ifu_done_o  (ifu_done),
    .ifu_rdata_o (ifu_rdata),
    .lsu_req_i   (lsu_mreq),
    .lsu_we_i    (lsu_mwe),
    .lsu_addr_i  (lsu_maddr),
    .lsu_wdata_i (lsu_mwdata),
    .lsu_done_o  (lsu_mdone),
    .lsu_rdata_o (lsu_mrdata),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i)
  );

  instr_fetch_unit #(
    .PADDR_WIDTH   (PADDR_WIDTH),
    .RESET_PC      (RESET_PC)
  ) instr_fetch_unit (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_ready_i (fetch_ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o    (fetch_pc_o),
    .fetch_instr_o (fetch_instr_o),
    .mem_req_o     (ifu_req),
    .mem_addr_o    (ifu_addr),
    .mem_done_i    (ifu_done),
    .mem_rdata_i   (ifu_rdata)
  );

  data_access_unit #(
    .PADDR_WIDTH (PADDR_WIDTH)
  ) data_access_unit (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (lsu_req_i),
    .we_i        (lsu_we_i),
    .addr_i      (lsu_addr_i),
    .size_i      (lsu_size_i),
    .wdata_i     (lsu_wdata_i),
    .busy_o      (lsu_busy_o),
    .done_o      (lsu_done_o),
    .rdata_o     (lsu_rdata_o),
    .mem_req_o   (lsu_mreq),
    .mem_we_o    (lsu_mwe),
    .mem_addr_o  (lsu_maddr),
    .mem_wdata_o (lsu_mwdata),
    .mem_done_i  (lsu_mdone),
    .mem_rdata_i (lsu_mrdata)
  );

endmodule

`default_nettype wire

//--- cpu_mem_port_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_mem_port_checker #(
  parameter int PADDR_WIDTH = 16
)(
  input  logic clk_i,
  input  logic rst_i,
  input  logic wb_cyc_o,
  input  logic wb_stb_o,
  input  logic wb_we_o,
  input  logic [PADDR_WIDTH-cpu_mem_pkg::LINE_OFF_BITS-1:0] wb_adr_o,
  input  cpu_mem_pkg::line_t wb_dat_o,
  input  logic wb_ack_i,
  input  logic lsu_done_o
);

  int fail_count = 0;

  // ======================================================================
  // Wishbone classic master
  // ======================================================================
  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_stb_o |-> wb_cyc_o)
    else begin
      $error("Wishbone stb high while cyc is low");
      fail_count++;
    end

  // Request held until the memory acknowledges
  request_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o)
      && $stable(wb_dat_o))
    else begin
      $error("Wishbone request changed or dropped before ack");
      fail_count++;
    end

  cyc_ends_after_ack: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_cyc_o && wb_ack_i |=> !wb_cyc_o)
    else begin
      $error("Wishbone cyc still high in the cycle after ack");
      fail_count++;
    end

  // Data side done is a single pulse
  lsu_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
    lsu_done_o |=> !lsu_done_o)
    else begin
      $error("Data unit done lasted more than one cycle");
      fail_count++;
    end

endmodule

bind mem_arbiter cpu_mem_port_checker #(
  .PADDR_WIDTH (PADDR_WIDTH)
) protocol_check (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .wb_cyc_o   (wb_cyc_o),
  .wb_stb_o   (wb_stb_o),
  .wb_we_o    (wb_we_o),
  .wb_adr_o   (wb_adr_o),
  .wb_dat_o   (wb_dat_o),
  .wb_ack_i   (wb_ack_i),
  .lsu_done_o (lsu_done_o)
);

`default_nettype wire

//--- tb_cpu_mem_port_tests.svh
// ======================================================================
// Fetch helpers
// ======================================================================
task automatic consume(input int n);
  int cycles;
  cycles = 0;
  got_pc.delete();
  got_instr.delete();
  fetch_ready_i = 1'b1;
  while (got_pc.size() < n && cycles < OP_CYCLES * (n + 4)) begin
    tick();
    cycles++;
  end
  fetch_ready_i = 1'b0;
  assert (got_pc.size() == n) else begin
    $display("Fetch stream stalled after %0d of %0d instructions", got_pc.size(), n);
    errors++;
  end
endtask

task automatic check_stream(input logic [15:0] start_pc);
  logic [15:0] pc;
  for (int i = 0; i < got_pc.size(); i++) begin
    pc = start_pc + 16'(4 * i);
    compare("fetch_pc_o", 32'(got_pc[i]), 32'(pc));
    compare("fetch_instr_o", got_instr[i], fill_word(int'(pc[15:4]), int'(pc[3:2])));
  end
endtask

task automatic wait_fetch_valid();
  int cycles;
  cycles = 0;
  while (!fetch_valid_o && cycles < OP_CYCLES) begin
    tick();
    cycles++;
  end
  assert (fetch_valid_o) else begin
    $display("Fetch never became valid at pc %h", fetch_pc_o);
    errors++;
  end
endtask

task automatic redirect_to(input logic [15:0] pc);
  redirect_i = 1'b1;
  redirect_pc_i = pc;
  tick();
  redirect_i = 1'b0;
endtask

// ======================================================================
// Load/store helpers
// ======================================================================
function automatic int size_bytes(input access_size_t size);
  return (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
endfunction

// Zero-extended value from the little-endian lanes of the shadow line
function automatic logic [31:0] expect_load(input logic [15:0] addr, input access_size_t size);
  logic [127:0] line;
  int base;
  logic [31:0] value;
  line = shadow[addr[11:4]];
  base = int'(addr[3:0]) & ~(size_bytes(size) - 1);
  value = '0;
  for (int k = 0; k < size_bytes(size); k++) begin
    value[8*k +: 8] = line[8*(base + k) +: 8];
  end
  return value;
endfunction

task automatic lsu_access(input logic we, input logic [15:0] addr, input access_size_t size,
                          input logic [31:0] wdata, output logic [31:0] rdata);
  int cycles;
  cycles = 0;
  while (lsu_busy_o && cycles < OP_CYCLES) begin
    tick();
    cycles++;
  end
  lsu_req_i = 1'b1;
  lsu_we_i = we;
  lsu_addr_i = addr;
  lsu_size_i = size;
  lsu_wdata_i = wdata;
  tick();
  lsu_req_i = 1'b0;
  compare("lsu_busy_o", 32'(lsu_busy_o), 32'd1);
  cycles = 0;
  while (!lsu_done_o && cycles < 2 * OP_CYCLES) begin
    tick();
    cycles++;
  end
  assert (lsu_done_o) else begin
    $display("Data access at %h never completed", addr);
    errors++;
  end
  rdata = lsu_rdata_o;
endtask

task automatic load_check(input logic [15:0] addr, input access_size_t size);
  logic [31:0] rdata;
  lsu_access(1'b0, addr, size, 32'h0, rdata);
  compare("lsu_rdata_o", rdata, expect_load(addr, size));
endtask

task automatic store_apply(input logic [15:0] addr, input access_size_t size,
                           input logic [31:0] wdata);
  logic [31:0] unused;
  int base;
  lsu_access(1'b1, addr, size, wdata, unused);
  base = int'(addr[3:0]) & ~(size_bytes(size) - 1);
  for (int k = 0; k < size_bytes(size); k++) begin
    shadow[addr[11:4]][8*(base + k) +: 8] = wdata[8*k +: 8];
  end
endtask

task automatic check_line_words(input logic [15:0] line_addr);
  for (int k = 0; k < 4; k++) begin
    load_check(line_addr + 16'(4 * k), SIZE_WORD);
  end
endtask

// ======================================================================
// Directed tests
// ======================================================================
task automatic test_reset_stream();
  int expected;
  consume(12);
  wait_fetch_valid();
  check_stream(RESET_PC);
  // One refill for each line entered plus the line after the last
  expected = int'((RESET_PC + 16'd48) >> 4) - int'(RESET_PC >> 4) + 1;
  compare("bus_cycles", 32'(bus_cycles), 32'(expected));
endtask

task automatic test_ready_hold();
  logic [15:0] held_pc;
  logic [31:0] held_instr;
  // Stream stopped after twelve instructions from the reset PC
  held_pc = RESET_PC + 16'd48;
  held_instr = fill_word(int'(held_pc[15:4]), int'(held_pc[3:2]));
  repeat (6) begin
    tick();
    compare("fetch_valid_o", 32'(fetch_valid_o), 32'd1);
    compare("fetch_pc_o", 32'(fetch_pc_o), 32'(held_pc));
    compare("fetch_instr_o", fetch_instr_o, held_instr);
  end
  consume(6);
  check_stream(held_pc);
endtask

task automatic test_redirect();
  int reads;
  redirect_to(16'h02A4);
  consume(2);
  check_stream(16'h02A4);
  reads = bus_cycles;
  redirect_to(16'h02A0);
  consume(2);
  check_stream(16'h02A0);
  compare("bus_cycles", 32'(bus_cycles), 32'(reads));
endtask

task automatic test_loads();
  for (int b = 0; b < 16; b++) begin
    load_check(16'h0900 + 16'(b), SIZE_BYTE);
  end
  for (int b = 0; b < 16; b += 2) begin
    load_check(16'h0900 + 16'(b), SIZE_HALF);
  end
  check_line_words(16'h0900);
endtask

task automatic test_stores();
  store_apply(16'h0915, SIZE_BYTE, 32'hDEAD_BEA7);
  check_line_words(16'h0910);
  store_apply(16'h091A, SIZE_HALF, 32'h1234_C3D2);
  check_line_words(16'h0910);
  store_apply(16'h091C, SIZE_WORD, 32'h0BAD_F00D);
  check_line_words(16'h0910);
endtask

task automatic test_concurrent();
  redirect_to(16'h0300);
  fork
    consume(16);
    begin
      store_apply(16'h0924, SIZE_WORD, 32'h5EED_1234);
      load_check(16'h0924, SIZE_WORD);
      store_apply(16'h0929, SIZE_BYTE, 32'h0000_0081);
      check_line_words(16'h0920);
      load_check(16'h092E, SIZE_HALF);
    end
  join
  check_stream(16'h0300);
endtask

//--- tb_cpu_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_mem_port;
  import cpu_mem_pkg::*;

  localparam int PADDR_WIDTH = 16;
  localparam logic [15:0] RESET_PC = 16'h0040;
  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS = 6;
  localparam int MAX_BUS_OPS = 64;
  // Worst case per bus operation, including one competing transfer
  localparam int OP_CYCLES = 16;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_BUS_OPS * OP_CYCLES;

  logic clk_i;
  logic rst_i;
  logic fetch_ready_i;
  logic redirect_i;
  logic [15:0] redirect_pc_i;
  logic fetch_valid_o;
  logic [15:0] fetch_pc_o;
  logic [31:0] fetch_instr_o;
  logic lsu_req_i;
  logic lsu_we_i;
  logic [15:0] lsu_addr_i;
  access_size_t lsu_size_i;
  logic [31:0] lsu_wdata_i;
  logic lsu_busy_o;
  logic lsu_done_o;
  logic [31:0] lsu_rdata_o;
  logic wb_cyc_o;
  logic wb_stb_o;
  logic wb_we_o;
  logic [11:0] wb_adr_o;
  logic [127:0] wb_dat_o;
  logic [127:0] wb_dat_i;
  logic wb_ack_i;

  logic [127:0] mem [256];
  logic [127:0] shadow [256];
  logic [15:0] lfsr_q;
  int bus_cycles;
  int errors;
  int assert_fails;

  // Memory model state, sampled at the falling edge
  logic req_seen;
  logic req_we;
  logic [7:0] req_adr;
  logic [127:0] req_dat;
  logic active;
  logic [1:0] wait_left;

  logic [15:0] got_pc [$];
  logic [31:0] got_instr [$];

  cpu_mem_port #(
    .PADDR_WIDTH (PADDR_WIDTH),
    .RESET_PC    (RESET_PC)
  ) uut (
    .clk_i (clk_i), .rst_i (rst_i),
    .fetch_ready_i (fetch_ready_i), .redirect_i (redirect_i),
    .redirect_pc_i (redirect_pc_i), .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o (fetch_pc_o), .fetch_instr_o (fetch_instr_o),
    .lsu_req_i (lsu_req_i), .lsu_we_i (lsu_we_i), .lsu_addr_i (lsu_addr_i),
    .lsu_size_i (lsu_size_i), .lsu_wdata_i (lsu_wdata_i),
    .lsu_busy_o (lsu_busy_o), .lsu_done_o (lsu_done_o), .lsu_rdata_o (lsu_rdata_o),
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_we_o (wb_we_o),
    .wb_adr_o (wb_adr_o), .wb_dat_o (wb_dat_o), .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Word k of line n, hashed from the full word address
  function automatic logic [31:0] fill_word(input int n, input int k);
    logic [31:0] wa;
    wa = 32'(n * 4 + k);
    return (wa * 32'h9E37_79B1) ^ {wa[15:0], ~wa[15:0]};
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [1:0] take_delay_bits();
    logic [1:0] bits;
    bits = '0;
    for (int i = 0; i < 2; i++) begin
      bits = {bits[0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return bits;
  endfunction

  // ======================================================================
  // Wishbone memory with 0 to 3 wait cycles
  // ======================================================================
  initial begin
    wb_ack_i = 1'b0;
    wb_dat_i = '0;
    lfsr_q = 16'd30235;
    bus_cycles = 0;
    active = 1'b0;
    wait_left = '0;
    for (int n = 0; n < 256; n++) begin
      for (int k = 0; k < 4; k++) begin
        mem[n][32*k +: 32] = fill_word(n, k);
        shadow[n][32*k +: 32] = fill_word(n, k);
      end
    end
    forever begin
      @(negedge clk_i);
      req_seen = rst_i && wb_cyc_o && wb_stb_o;
      req_we = wb_we_o;
      req_adr = wb_adr_o[7:0];
      req_dat = wb_dat_o;
      @(posedge clk_i);
      #2;
      if (wb_ack_i) begin
        wb_ack_i = 1'b0;
      end else if (req_seen) begin
        if (!active) begin
          active = 1'b1;
          bus_cycles++;
          wait_left = take_delay_bits();
        end
        if (wait_left == 2'd0) begin
          active = 1'b0;
          wb_ack_i = 1'b1;
          if (req_we) begin
            mem[req_adr] = req_dat;
          end else begin
            wb_dat_i = mem[req_adr];
          end
        end else begin
          wait_left--;
        end
      end
    end
  end

  // Consumed instructions, valid and ready before the edge
  always @(negedge clk_i) begin
    if (rst_i && fetch_valid_o && fetch_ready_i && !redirect_i) begin
      got_pc.push_back(fetch_pc_o);
      got_instr.push_back(fetch_instr_o);
    end
  end

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  `include "tb_cpu_mem_port_tests.svh"

  initial begin
    #(CLK_PERIOD * (10 + WATCHDOG_CYCLES));
    $display("Watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors: %0d failed checks, %0d failed assertions", errors,
             uut.mem_arbiter.protocol_check.fail_count);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    errors = 0;
    rst_i = 1'b0;
    fetch_ready_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    lsu_req_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_addr_i = '0;
    lsu_size_i = SIZE_WORD;
    lsu_wdata_i = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_i = 1'b1;
    test_reset_stream();
    test_ready_hold();
    test_redirect();
    test_loads();
    test_stores();
    test_concurrent();
    repeat (8) tick();
    assert_fails = uut.mem_arbiter.protocol_check.fail_count;
    $display("Errors: %0d failed checks, %0d failed assertions", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_mem_port.f
+incdir+.
cpu_mem_pkg.sv
mem_arbiter.sv
instr_fetch_unit.sv
data_access_unit.sv
cpu_mem_port.sv
cpu_mem_port_checker.sv
tb_cpu_mem_port.sv
